/* src.f */
+incdir+testbench
verilog/rv_isa_pkg.sv
verilog/dec_ctrl_pkg.sv
verilog/dec_if.sv
verilog/imm_gen.sv
verilog/op_decoder.sv
verilog/pc_ctrl.sv
verilog/decode_out_reg.sv
verilog/decode_stage.sv
testbench/tb_decode_stage.sv

/* Makefile */
BIN := obj_dir/Vtb_decode_stage

.PHONY: all run clean

all: run

$(BIN): src.f $(wildcard verilog/*.sv testbench/*.sv testbench/*.svh)
	verilator --binary --timing --top-module tb_decode_stage -f src.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

/* testbench/tb_decode_ref.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

typedef struct packed {
	logic [XLEN-1:0] pc;
	dec_ctrl_t       ctrl;
} exp_item_t;

// Decoded items accepted by the DUT and not yet seen at the output
exp_item_t exp_q[$];

function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
	logic signed [31:0] s;
	s = $signed(v << (32 - bits));
	return s >>> (32 - bits);
endfunction

function automatic alu_op_t alu_for_funct3(input logic [2:0] f3, input logic alt);
	case (f3)
		3'd0:    return ALUOP_ADD;
		3'd1:    return ALUOP_SLL;
		3'd2:    return ALUOP_LT;
		3'd3:    return ALUOP_LTU;
		3'd4:    return ALUOP_XOR;
		3'd5:    return alt ? ALUOP_SRA : ALUOP_SRL;
		3'd6:    return ALUOP_OR;
		default: return ALUOP_AND;
	endcase
endfunction

// ------------------------------
// Expected execute controls for one instruction word

function automatic dec_ctrl_t ref_decode(input instr_t w, input logic ferr);
	dec_ctrl_t   c;
	logic        bad;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] b_imm;
	logic [31:0] j_imm;
	logic [31:0] u_imm;

	f3    = w[14:12];
	f7    = w[31:25];
	i_imm = sext({20'b0, w[31:20]}, 12);
	s_imm = sext({20'b0, w[31:25], w[11:7]}, 12);
	b_imm = sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
	j_imm = sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
	u_imm = {w[31:12], 12'b0};

	c     = '0;
	c.rs1 = w[19:15];
	c.rs2 = w[24:20];
	c.rd  = w[11:7];
	c.imm = i_imm;
	bad   = 1'b0;

	case (w[6:0])
		OPC_LUI, OPC_AUIPC: begin
			c.imm      = u_imm;
			c.alusrc_b = ALUSRCB_IMM;
			c.rs1      = '0;
			c.rs2      = '0;
			if (w[6:0] == OPC_LUI)
				c.alu_op = ALUOP_RS2;
			else
				c.alusrc_a = ALUSRCA_PC;
		end
		OPC_JAL, OPC_JALR: begin
			// The ALU makes the link address, the target is base plus offset
			c.imm             = 32'd4;
			c.bcond           = BCOND_ALWAYS;
			c.alusrc_a        = ALUSRCA_PC;
			c.alusrc_b        = ALUSRCB_IMM;
			c.rs2             = '0;
			c.addr_is_regoffs = (w[6:0] == OPC_JALR);
			c.addr_offs       = (w[6:0] == OPC_JALR) ? i_imm : j_imm;
			if (w[6:0] == OPC_JAL)
				c.rs1 = '0;
			else
				bad = (f3 != 3'd0);
		end
		OPC_BRANCH: begin
			c.addr_offs = b_imm;
			c.rd        = '0;
			case (f3)
				3'd0, 3'd1: c.alu_op = ALUOP_SUB;
				3'd4, 3'd5: c.alu_op = ALUOP_LT;
				3'd6, 3'd7: c.alu_op = ALUOP_LTU;
				default:    bad = 1'b1;
			endcase
			// BEQ, BGE and BGEU are taken when the compare gives zero
			c.bcond = (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7) ? BCOND_ZERO : BCOND_NZERO;
		end
		OPC_LOAD: begin
			c.addr_offs       = i_imm;
			c.addr_is_regoffs = 1'b1;
			c.rs2             = '0;
			case (f3)
				3'd0:    c.mem_op = MEMOP_LB;
				3'd1:    c.mem_op = MEMOP_LH;
				3'd2:    c.mem_op = MEMOP_LW;
				3'd4:    c.mem_op = MEMOP_LBU;
				3'd5:    c.mem_op = MEMOP_LHU;
				default: bad = 1'b1;
			endcase
		end
		OPC_STORE: begin
			c.addr_offs       = s_imm;
			c.addr_is_regoffs = 1'b1;
			c.alu_op          = ALUOP_RS2;
			c.rd              = '0;
			case (f3)
				3'd0:    c.mem_op = MEMOP_SB;
				3'd1:    c.mem_op = MEMOP_SH;
				3'd2:    c.mem_op = MEMOP_SW;
				default: bad = 1'b1;
			endcase
		end
		OPC_OP_IMM: begin
			c.alusrc_b = ALUSRCB_IMM;
			c.rs2      = '0;
			c.alu_op   = alu_for_funct3(f3, f7 == FUNCT7_ALT);
			if (f3 == 3'd1)
				bad = (f7 != 7'h00);
			if (f3 == 3'd5)
				bad = (f7 != 7'h00) && (f7 != FUNCT7_ALT);
		end
		OPC_OP: begin
			if (f7 == FUNCT7_MULDIV) begin
				// M operations are numbered in funct3 order
				c.alu_op = ALUOP_MULDIV;
				c.mul_op = mul_op_t'(f3);
			end else if (f7 == 7'h00 || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
				c.alu_op = (f7 == FUNCT7_ALT && f3 == 3'd0) ? ALUOP_SUB :
					alu_for_funct3(f3, f7 == FUNCT7_ALT);
			end else begin
				bad = 1'b1;
			end
		end
		OPC_MISC_MEM: begin
			c.rs2 = '0;
			bad   = (f3 != 3'd0) || (w[19:15] != 5'd0) || (w[11:7] != 5'd0);
		end
		OPC_SYSTEM: begin
			c.rs1 = '0;
			c.rs2 = '0;
			c.rd  = '0;
			if (w == 32'h0000_0073)
				c.except = EXCEPT_ECALL;
			else if (w == 32'h0010_0073)
				c.except = EXCEPT_EBREAK;
			else
				bad = 1'b1;
		end
		default: bad = 1'b1;
	endcase

	if (bad || ferr) begin
		c.rs1             = '0;
		c.rs2             = '0;
		c.rd              = '0;
		c.mem_op          = MEMOP_NONE;
		c.bcond           = BCOND_NEVER;
		c.alu_op          = ALUOP_ADD;
		c.addr_is_regoffs = 1'b1;
		c.except          = ferr ? EXCEPT_INSTR_FAULT : EXCEPT_INSTR_ILLEGAL;
	end
	return c;
endfunction

task automatic push_expected(input logic [XLEN-1:0] pc, input instr_t word, input logic ferr);
	exp_item_t item;
	item.pc   = pc;
	item.ctrl = ref_decode(word, ferr);
	exp_q.push_back(item);
endtask

`endif

/* testbench/tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage;
	import rv_isa_pkg::*;
	import dec_ctrl_pkg::*;

	`include "tb_decode_ref.svh"

	logic                clk;
	logic                rst_n;
	logic                instr_valid_i;
	logic                instr_ready_o;
	instr_t              instr_i;
	logic                fetch_err_i;
	logic                jump_i;
	logic [XLEN-1:0]     jump_target_i;
	logic                out_valid_o;
	logic                out_ready_i;
	logic [XLEN-1:0]     out_pc_o;
	reg_addr_t           out_rs1_o;
	reg_addr_t           out_rs2_o;
	reg_addr_t           out_rd_o;
	logic [XLEN-1:0]     out_imm_o;
	logic [XLEN-1:0]     out_addr_offs_o;
	logic                out_addr_is_regoffs_o;
	logic [W_ALUOP-1:0]  out_alu_op_o;
	logic                out_alusrc_a_o;
	logic                out_alusrc_b_o;
	logic [W_MEMOP-1:0]  out_mem_op_o;
	logic [W_MULOP-1:0]  out_mul_op_o;
	logic [W_BCOND-1:0]  out_bcond_o;
	logic [W_EXCEPT-1:0] out_except_o;

	int              errors;
	int              cycles;
	int              cycle_limit;
	logic            draining;
	logic            model_full;
	logic            first_done;
	logic [XLEN-1:0] model_pc;
	instr_t          stim_word[$];
	logic            stim_err[$];

	decode_stage dut (.*);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	// ------------------------------
	// Instruction encoders

	function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic instr_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd9, 5'd8, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic build_stimulus();
		instr_t directed[$];
		instr_t w;
		for (int f = 0; f < 8; f++) begin
			directed.push_back(enc_r(7'h00, 5'd3, 5'd2, 3'(f), 5'd1));
			directed.push_back(enc_r(FUNCT7_MULDIV, 5'd6, 5'd5, 3'(f), 5'd4));
			directed.push_back(enc_i(12'h013, 5'd7, 3'(f), 5'd8, OPC_OP_IMM));
			directed.push_back(enc_b((f % 2 == 0) ? 13'h1ff4 : 13'h0810, 3'(f)));
			directed.push_back(enc_i(12'h7fc, 5'd10, 3'(f), 5'd11, OPC_LOAD));
			directed.push_back(enc_s(12'h804, 5'd12, 5'd13, 3'(f)));
		end
		directed.push_back(enc_r(FUNCT7_ALT, 5'd3, 5'd2, 3'd0, 5'd1));
		directed.push_back(enc_r(FUNCT7_ALT, 5'd3, 5'd2, 3'd5, 5'd1));
		directed.push_back(enc_r(FUNCT7_ALT, 5'd3, 5'd2, 3'd1, 5'd1));
		directed.push_back(enc_r(7'h10, 5'd3, 5'd2, 3'd0, 5'd1));
		directed.push_back(enc_i({FUNCT7_ALT, 5'd9}, 5'd7, 3'd5, 5'd8, OPC_OP_IMM));
		directed.push_back(enc_i({FUNCT7_ALT, 5'd9}, 5'd7, 3'd1, 5'd8, OPC_OP_IMM));
		directed.push_back(enc_i(12'hf85, 5'd7, 3'd0, 5'd8, OPC_OP_IMM));
		directed.push_back({20'hdead0, 5'd14, OPC_LUI});
		directed.push_back({20'h80001, 5'd15, OPC_AUIPC});
		directed.push_back(enc_j(21'h1ff800, 5'd1));
		directed.push_back(enc_j(21'h00408, 5'd1));
		directed.push_back(enc_i(12'hffc, 5'd1, 3'd0, 5'd0, OPC_JALR));
		directed.push_back(enc_i(12'h010, 5'd1, 3'd1, 5'd0, OPC_JALR));
		directed.push_back(32'h0ff0_000f);
		directed.push_back(32'h0000_100f);
		directed.push_back(32'h0000_0073);
		directed.push_back(32'h0010_0073);
		directed.push_back(32'h3000_2573);
		directed.push_back(32'hffff_ffff);
		directed.push_back(32'h0000_0000);
		foreach (directed[i]) begin
			stim_word.push_back(directed[i]);
			stim_err.push_back(1'b0);
		end
		// Random register fields on known words, or fully random words
		for (int k = 0; k < 200; k++) begin
			if ($urandom % 4 == 0)
				w = $urandom;
			else
				w = directed[$urandom % directed.size()] ^ ($urandom & 32'h01ff_8f80);
			stim_word.push_back(w);
			stim_err.push_back($urandom % 8 == 0);
		end
	endtask

	// ------------------------------
	// Output back-pressure and jumps from execute

	// No jump until the first word is taken, so that word shows the reset PC
	always @(negedge clk) begin
		if (draining) begin
			out_ready_i = 1'b1;
			jump_i      = 1'b0;
		end else begin
			out_ready_i   = ($urandom % 3 != 0);
			jump_i        = first_done && ($urandom % 16 == 0);
			jump_target_i = $urandom & 32'hffff_fffc;
		end
	end

	// Model PC, register occupancy and expected queue follow the handshakes
	always @(posedge clk) begin
		if (rst_n) begin
			check_value("out_valid_o", 32'(out_valid_o), 32'(model_full));
			check_value("instr_ready_o", 32'(instr_ready_o),
				32'((!model_full || out_ready_i) && !jump_i));
			if (jump_i) begin
				model_pc   = jump_target_i;
				model_full = 1'b0;
			end else if (instr_valid_i && instr_ready_o) begin
				push_expected(model_pc, instr_i, fetch_err_i);
				model_pc   = model_pc + 32'd4;
				model_full = 1'b1;
				first_done = 1'b1;
			end else if (out_ready_i) begin
				model_full = 1'b0;
			end
		end
	end

	task automatic compare_front();
		exp_item_t e;
		e = exp_q.pop_front();
		check_value("out_pc_o", out_pc_o, e.pc);
		check_value("out_rs1_o", 32'(out_rs1_o), 32'(e.ctrl.rs1));
		check_value("out_rs2_o", 32'(out_rs2_o), 32'(e.ctrl.rs2));
		check_value("out_rd_o", 32'(out_rd_o), 32'(e.ctrl.rd));
		check_value("out_imm_o", out_imm_o, e.ctrl.imm);
		check_value("out_addr_offs_o", out_addr_offs_o, e.ctrl.addr_offs);
		check_value("out_addr_is_regoffs_o", 32'(out_addr_is_regoffs_o),
			32'(e.ctrl.addr_is_regoffs));
		check_value("out_alu_op_o", 32'(out_alu_op_o), 32'(e.ctrl.alu_op));
		check_value("out_alusrc_a_o", 32'(out_alusrc_a_o), 32'(e.ctrl.alusrc_a));
		check_value("out_alusrc_b_o", 32'(out_alusrc_b_o), 32'(e.ctrl.alusrc_b));
		check_value("out_mem_op_o", 32'(out_mem_op_o), 32'(e.ctrl.mem_op));
		check_value("out_mul_op_o", 32'(out_mul_op_o), 32'(e.ctrl.mul_op));
		check_value("out_bcond_o", 32'(out_bcond_o), 32'(e.ctrl.bcond));
		check_value("out_except_o", 32'(out_except_o), 32'(e.ctrl.except));
	endtask

	always @(posedge clk) begin
		if (rst_n && out_valid_o) begin
			if (out_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("ERROR: an instruction came out that was never accepted");
					errors++;
				end else begin
					compare_front();
				end
			end else if (jump_i && exp_q.size() != 0) begin
				// The held item is flushed and never reaches execute
				exp_q.delete(0);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("ERROR: run did not finish within %0d cycles", cycle_limit);
			errors++;
			end_run();
		end
	end

	initial begin
		void'($urandom(32'h633a));
		clk           = 1'b0;
		rst_n         = 1'b0;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		fetch_err_i   = 1'b0;
		jump_i        = 1'b0;
		jump_target_i = '0;
		out_ready_i   = 1'b0;
		errors        = 0;
		cycles        = 0;
		draining      = 1'b0;
		model_full    = 1'b0;
		first_done    = 1'b0;
		model_pc      = RESET_VECTOR;
		build_stimulus();
		cycle_limit = 10 * stim_word.size() + 100;

		repeat (5) @(negedge clk);
		check_value("out_valid_o", 32'(out_valid_o), 32'h0);
		rst_n = 1'b1;

		foreach (stim_word[i]) begin
			while ($urandom % 4 == 0)
				@(negedge clk);
			instr_valid_i = 1'b1;
			instr_i       = stim_word[i];
			fetch_err_i   = stim_err[i];
			do
				@(posedge clk);
			while (!instr_ready_o);
			@(negedge clk);
			instr_valid_i = 1'b0;
			instr_i       = $urandom;
			fetch_err_i   = 1'b0;
		end

		draining = 1'b1;
		repeat (4) @(negedge clk);
		check_value("out_valid_o", 32'(out_valid_o), 32'h0);
		if (exp_q.size() != 0) begin
			$display("ERROR: %0d accepted instructions were lost", exp_q.size());
			errors++;
		end
		end_run();
	end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic                                instr_valid_i,
	output logic                                instr_ready_o,
	input  rv_isa_pkg::instr_t                  instr_i,
	input  logic                                fetch_err_i,

	input  logic                                jump_i,
	input  logic [rv_isa_pkg::XLEN-1:0]         jump_target_i,

	output logic                                out_valid_o,
	input  logic                                out_ready_i,
	output logic [rv_isa_pkg::XLEN-1:0]         out_pc_o,
	output rv_isa_pkg::reg_addr_t               out_rs1_o,
	output rv_isa_pkg::reg_addr_t               out_rs2_o,
	output rv_isa_pkg::reg_addr_t               out_rd_o,
	output logic [rv_isa_pkg::XLEN-1:0]         out_imm_o,
	output logic [rv_isa_pkg::XLEN-1:0]         out_addr_offs_o,
	output logic                                out_addr_is_regoffs_o,
	output logic [dec_ctrl_pkg::W_ALUOP-1:0]    out_alu_op_o,
	output logic                                out_alusrc_a_o,
	output logic                                out_alusrc_b_o,
	output logic [dec_ctrl_pkg::W_MEMOP-1:0]    out_mem_op_o,
	output logic [dec_ctrl_pkg::W_MULOP-1:0]    out_mul_op_o,
	output logic [dec_ctrl_pkg::W_BCOND-1:0]    out_bcond_o,
	output logic [dec_ctrl_pkg::W_EXCEPT-1:0]   out_except_o
);
	import rv_isa_pkg::*;
	import dec_ctrl_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] addr_offs;
	dec_ctrl_t       out_ctrl;

	dec_if dec_bus ();

	assign dec_bus.pc    = pc;
	assign instr_ready_o = dec_bus.ready;

	imm_gen u_imm_gen (
		.instr_i     (instr_i),
		.imm_o       (imm),
		.addr_offs_o (addr_offs)
	);

	op_decoder u_op_decoder (
		.instr_i       (instr_i),
		.fetch_err_i   (fetch_err_i),
		.instr_valid_i (instr_valid_i),
		.imm_i         (imm),
		.addr_offs_i   (addr_offs),
		.dec           (dec_bus.src)
	);

	pc_ctrl u_pc_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid_i (instr_valid_i),
		.instr_ready_i (dec_bus.ready),
		.jump_i        (jump_i),
		.jump_target_i (jump_target_i),
		.pc_o          (pc)
	);

	decode_out_reg u_out_reg (
		.clk         (clk),
		.rst_n       (rst_n),
		.jump_i      (jump_i),
		.dec         (dec_bus.dst),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_pc_o    (out_pc_o),
		.out_ctrl_o  (out_ctrl)
	);

	// ------------------------------
	// Struct fields out to plain ports

	assign out_rs1_o             = out_ctrl.rs1;
	assign out_rs2_o             = out_ctrl.rs2;
	assign out_rd_o              = out_ctrl.rd;
	assign out_imm_o             = out_ctrl.imm;
	assign out_addr_offs_o       = out_ctrl.addr_offs;
	assign out_addr_is_regoffs_o = out_ctrl.addr_is_regoffs;
	assign out_alu_op_o          = out_ctrl.alu_op;
	assign out_alusrc_a_o        = out_ctrl.alusrc_a;
	assign out_alusrc_b_o        = out_ctrl.alusrc_b;
	assign out_mem_op_o          = out_ctrl.mem_op;
	assign out_mul_op_o          = out_ctrl.mul_op;
	assign out_bcond_o           = out_ctrl.bcond;
	assign out_except_o          = out_ctrl.except;

endmodule

`default_nettype wire

/* verilog/decode_out_reg.sv */
`default_nettype none

module decode_out_reg (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          jump_i,
	dec_if.dst                            dec,
	output logic                          out_valid_o,
	input  logic                          out_ready_i,
	output logic [rv_isa_pkg::XLEN-1:0]   out_pc_o,
	output dec_ctrl_pkg::dec_ctrl_t       out_ctrl_o
);
	import rv_isa_pkg::*;
	import dec_ctrl_pkg::*;

	logic            full;
	logic            take;
	logic [XLEN-1:0] pc_q;
	dec_ctrl_t       ctrl_q;

	// Accept when empty or when the held item leaves on this same edge
	assign dec.ready = (!full || out_ready_i) && !jump_i;
	assign take      = dec.valid && dec.ready;

	assign out_valid_o = full;
	assign out_pc_o    = pc_q;
	assign out_ctrl_o  = ctrl_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (jump_i) begin
			full <= 1'b0;
		end else if (take) begin
			full <= 1'b1;
		end else if (out_ready_i) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pc_q   <= dec.pc;
			ctrl_q <= dec.ctrl;
		end
	end

endmodule

`default_nettype wire

/* verilog/pc_ctrl.sv */
`default_nettype none

module pc_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          instr_valid_i,
	input  logic                          instr_ready_i,
	input  logic                          jump_i,
	input  logic [rv_isa_pkg::XLEN-1:0]   jump_target_i,
	output logic [rv_isa_pkg::XLEN-1:0]   pc_o
);
	import rv_isa_pkg::*;

	logic [XLEN-1:0] pc;

	assign pc_o = pc;

	// A jump wins over a sequential step, ready is low during a jump anyway
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_VECTOR;
		end else if (jump_i) begin
			pc <= jump_target_i;
		end else if (instr_valid_i && instr_ready_i) begin
			pc <= pc + 32'd4;
		end
	end

endmodule

`default_nettype wire

/* verilog/op_decoder.sv */
`default_nettype none

module op_decoder (
	input  rv_isa_pkg::instr_t  instr_i,
	input  logic                fetch_err_i,
	input  logic                instr_valid_i,
	input  logic [31:0]         imm_i,
	input  logic [31:0]         addr_offs_i,
	dec_if.src                  dec
);
	import rv_isa_pkg::*;
	import dec_ctrl_pkg::*;

	localparam reg_addr_t X0 = '0;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;
	dec_ctrl_t  ctrl;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// Valid is passed through untouched, it never looks at ready
	assign dec.valid = instr_valid_i;
	assign dec.ctrl  = ctrl;

	always_comb begin
		ctrl.rs1             = instr_i[19:15];
		ctrl.rs2             = instr_i[24:20];
		ctrl.rd              = instr_i[11:7];
		ctrl.imm             = imm_i;
		ctrl.addr_offs       = addr_offs_i;
		ctrl.addr_is_regoffs = 1'b0;
		ctrl.alu_op          = ALUOP_ADD;
		ctrl.alusrc_a        = ALUSRCA_RS1;
		ctrl.alusrc_b        = ALUSRCB_RS2;
		ctrl.mem_op          = MEMOP_NONE;
		ctrl.mul_op          = M_OP_MUL;
		ctrl.bcond           = BCOND_NEVER;
		ctrl.except          = EXCEPT_NONE;
		illegal              = 1'b0;

		case (opcode)
			OPC_LUI: begin
				ctrl.alu_op   = ALUOP_RS2;
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.rs1      = X0;
				ctrl.rs2      = X0;
			end
			OPC_AUIPC: begin
				ctrl.alusrc_a = ALUSRCA_PC;
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.rs1      = X0;
				ctrl.rs2      = X0;
			end
			OPC_JAL, OPC_JALR: begin
				// Link value is pc + 4, the target comes from addr_offs
				ctrl.bcond           = BCOND_ALWAYS;
				ctrl.alusrc_a        = ALUSRCA_PC;
				ctrl.alusrc_b        = ALUSRCB_IMM;
				ctrl.rs2             = X0;
				ctrl.addr_is_regoffs = (opcode == OPC_JALR);
				if (opcode == OPC_JAL)
					ctrl.rs1 = X0;
				else
					illegal = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				ctrl.rd = X0;
				case (funct3)
					3'b000:  ctrl.alu_op = ALUOP_SUB;
					3'b001:  ctrl.alu_op = ALUOP_SUB;
					3'b100:  ctrl.alu_op = ALUOP_LT;
					3'b101:  ctrl.alu_op = ALUOP_LT;
					3'b110:  ctrl.alu_op = ALUOP_LTU;
					3'b111:  ctrl.alu_op = ALUOP_LTU;
					default: illegal = 1'b1;
				endcase
				// BEQ, BGE and BGEU take the branch on a zero ALU result
				ctrl.bcond = (funct3[0] ^ funct3[2]) ? BCOND_NZERO : BCOND_ZERO;
			end
			OPC_LOAD: begin
				ctrl.addr_is_regoffs = 1'b1;
				ctrl.rs2             = X0;
				case (funct3)
					3'b000:  ctrl.mem_op = MEMOP_LB;
					3'b001:  ctrl.mem_op = MEMOP_LH;
					3'b010:  ctrl.mem_op = MEMOP_LW;
					3'b100:  ctrl.mem_op = MEMOP_LBU;
					3'b101:  ctrl.mem_op = MEMOP_LHU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				// Store data goes through the ALU as rs2
				ctrl.addr_is_regoffs = 1'b1;
				ctrl.alu_op          = ALUOP_RS2;
				ctrl.rd              = X0;
				case (funct3)
					3'b000:  ctrl.mem_op = MEMOP_SB;
					3'b001:  ctrl.mem_op = MEMOP_SH;
					3'b010:  ctrl.mem_op = MEMOP_SW;
					default: illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				ctrl.alusrc_b = ALUSRCB_IMM;
				ctrl.rs2      = X0;
				case (funct3)
					3'b000: ctrl.alu_op = ALUOP_ADD;
					3'b001: begin
						ctrl.alu_op = ALUOP_SLL;
						illegal     = (funct7 != 7'b0000000);
					end
					3'b010: ctrl.alu_op = ALUOP_LT;
					3'b011: ctrl.alu_op = ALUOP_LTU;
					3'b100: ctrl.alu_op = ALUOP_XOR;
					3'b101: begin
						ctrl.alu_op = (funct7 == FUNCT7_ALT) ? ALUOP_SRA : ALUOP_SRL;
						illegal     = (funct7 != 7'b0000000) && (funct7 != FUNCT7_ALT);
					end
					3'b110: ctrl.alu_op = ALUOP_OR;
					default: ctrl.alu_op = ALUOP_AND;
				endcase
			end
			OPC_OP: begin
				if (funct7 == FUNCT7_MULDIV) begin
					ctrl.alu_op = ALUOP_MULDIV;
					ctrl.mul_op = mul_op_t'(funct3);
				end else if (funct7 == FUNCT7_ALT) begin
					case (funct3)
						3'b000:  ctrl.alu_op = ALUOP_SUB;
						3'b101:  ctrl.alu_op = ALUOP_SRA;
						default: illegal = 1'b1;
					endcase
				end else if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000:  ctrl.alu_op = ALUOP_ADD;
						3'b001:  ctrl.alu_op = ALUOP_SLL;
						3'b010:  ctrl.alu_op = ALUOP_LT;
						3'b011:  ctrl.alu_op = ALUOP_LTU;
						3'b100:  ctrl.alu_op = ALUOP_XOR;
						3'b101:  ctrl.alu_op = ALUOP_SRL;
						3'b110:  ctrl.alu_op = ALUOP_OR;
						default: ctrl.alu_op = ALUOP_AND;
					endcase
				end else begin
					illegal = 1'b1;
				end
			end
			OPC_MISC_MEM: begin
				// FENCE runs as a no-op, rs1 and rd must be zero in the word
				ctrl.rs2 = X0;
				illegal  = (funct3 != 3'b000) || (instr_i[19:15] != X0) ||
					(instr_i[11:7] != X0);
			end
			OPC_SYSTEM: begin
				ctrl.rs1 = X0;
				ctrl.rs2 = X0;
				ctrl.rd  = X0;
				if (instr_i == INSTR_ECALL)
					ctrl.except = EXCEPT_ECALL;
				else if (instr_i == INSTR_EBREAK)
					ctrl.except = EXCEPT_EBREAK;
				else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;
		endcase

		// ------------------------------
		// Faulting instructions must have no side effects in execute
		if (illegal || fetch_err_i) begin
			ctrl.rs1             = X0;
			ctrl.rs2             = X0;
			ctrl.rd              = X0;
			ctrl.mem_op          = MEMOP_NONE;
			ctrl.bcond           = BCOND_NEVER;
			ctrl.alu_op          = ALUOP_ADD;
			ctrl.addr_is_regoffs = 1'b1;
			ctrl.except          = fetch_err_i ? EXCEPT_INSTR_FAULT : EXCEPT_INSTR_ILLEGAL;
		end
	end

endmodule

`default_nettype wire

/* verilog/imm_gen.sv */
`default_nettype none

module imm_gen (
	input  rv_isa_pkg::instr_t  instr_i,
	output logic [31:0]         imm_o,
	output logic [31:0]         addr_offs_o
);
	import rv_isa_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Jumps put the link value pc + 4 through the ALU, so their ALU immediate is 4
	always_comb begin
		case (instr_i[6:0])
			OPC_LUI, OPC_AUIPC: imm_o = imm_u;
			OPC_JAL, OPC_JALR:  imm_o = 32'h0000_0004;
			default:            imm_o = imm_i;
		endcase
	end

	always_comb begin
		case (instr_i[6:0])
			OPC_JAL:            addr_offs_o = imm_j;
			OPC_BRANCH:         addr_offs_o = imm_b;
			OPC_STORE:          addr_offs_o = imm_s;
			OPC_LOAD, OPC_JALR: addr_offs_o = imm_i;
			default:            addr_offs_o = 32'h0000_0000;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/dec_if.sv */
`default_nettype none

interface dec_if;
	import rv_isa_pkg::*;
	import dec_ctrl_pkg::*;

	logic            valid;
	logic            ready;
	logic [XLEN-1:0] pc;
	dec_ctrl_t       ctrl;

	// The PC is attached by the stage top, not by the decoder
	modport src (
		output valid,
		output ctrl
	);

	modport dst (
		input  valid,
		input  pc,
		input  ctrl,
		output ready
	);

endinterface

`default_nettype wire

/* verilog/dec_ctrl_pkg.sv */
`default_nettype none

package dec_ctrl_pkg;

	localparam int W_ALUOP  = 4;
	localparam int W_MEMOP  = 4;
	localparam int W_MULOP  = 3;
	localparam int W_BCOND  = 2;
	localparam int W_EXCEPT = 3;

	typedef enum logic [W_ALUOP-1:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_SLL, ALUOP_LT, ALUOP_LTU, ALUOP_XOR,
		ALUOP_SRL, ALUOP_SRA, ALUOP_OR, ALUOP_AND, ALUOP_RS2, ALUOP_MULDIV
	} alu_op_t;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alu_src_a_t;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alu_src_b_t;

	typedef enum logic [W_MEMOP-1:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU, MEMOP_LHU,
		MEMOP_SB, MEMOP_SH, MEMOP_SW
	} mem_op_t;

	// Encoded in funct3 order so the decoder can take funct3 directly
	typedef enum logic [W_MULOP-1:0] {
		M_OP_MUL, M_OP_MULH, M_OP_MULHSU, M_OP_MULHU,
		M_OP_DIV, M_OP_DIVU, M_OP_REM, M_OP_REMU
	} mul_op_t;

	typedef enum logic [W_BCOND-1:0] {
		BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO
	} bcond_t;

	typedef enum logic [W_EXCEPT-1:0] {
		EXCEPT_NONE, EXCEPT_INSTR_ILLEGAL, EXCEPT_INSTR_FAULT, EXCEPT_ECALL, EXCEPT_EBREAK
	} except_t;

	typedef struct packed {
		rv_isa_pkg::reg_addr_t           rs1;
		rv_isa_pkg::reg_addr_t           rs2;
		rv_isa_pkg::reg_addr_t           rd;
		logic [rv_isa_pkg::XLEN-1:0]     imm;
		logic [rv_isa_pkg::XLEN-1:0]     addr_offs;
		logic                            addr_is_regoffs;
		alu_op_t                         alu_op;
		alu_src_a_t                      alusrc_a;
		alu_src_b_t                      alusrc_b;
		mem_op_t                         mem_op;
		mul_op_t                         mul_op;
		bcond_t                          bcond;
		except_t                         except;
	} dec_ctrl_t;

endpackage

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	typedef logic [31:0]       instr_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// ------------------------------
	// Major opcodes, bits [6:0] of the instruction word

	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// ------------------------------
	// Function fields

	// SUB and SRA/SRAI set bit 30
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// The only two SYSTEM encodings kept are fully fixed words
	localparam instr_t INSTR_ECALL  = 32'h0000_0073;
	localparam instr_t INSTR_EBREAK = 32'h0010_0073;

	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0100;

endpackage

`default_nettype wire
